// ==== hdl/ntm_divider_pkg.sv ====
package ntm_divider_pkg;

  ////////////////////////////////////////
  // Datapath widths
  ////////////////////////////////////////

  // Operand, modulus and result width
  localparam int DATA_WIDTH = 16;

  // Vector length and element counters
  // 255 elements at most
  localparam int INDEX_WIDTH = 8;

  ////////////////////////////////////////
  // Lane organisation
  ////////////////////////////////////////

  // Even elements to lane 0, odd elements to lane 1
  localparam int LANE_COUNT = 2;

  // Bits needed to name one lane
  localparam int LANE_SEL_WIDTH = $clog2(LANE_COUNT);

  ////////////////////////////////////////
  // Scalar divider latency
  ////////////////////////////////////////

  // Load cycle, quotient pass, modulus pass
  // Start pulse to done pulse, in cycles
  localparam int DIVIDE_STEPS = 2 * DATA_WIDTH + 1;

endpackage

// ==== hdl/ntm_scalar_divider.sv ====
`timescale 1ns/1ns

module ntm_scalar_divider
  import ntm_divider_pkg::*;
(
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  start,
  input  logic [DATA_WIDTH-1:0] modulo,
  input  logic [DATA_WIDTH-1:0] data_a,
  input  logic [DATA_WIDTH-1:0] data_b,
  output logic                  done,
  output logic [DATA_WIDTH-1:0] result
);

  ////////////////////////////////////////
  // Signals
  ////////////////////////////////////////

  // Control
  logic                            busy;
  logic [$clog2(DIVIDE_STEPS)-1:0] step;
  logic                            modulo_pass;
  logic                            quot_end;
  logic                            last_step;

  // Dividend bits, consumed from the top
  // Quotient bits enter at the bottom
  logic [DATA_WIDTH-1:0] work;
  logic [DATA_WIDTH-1:0] work_next;

  // Partial remainder
  logic [DATA_WIDTH-1:0] rem;
  logic [DATA_WIDTH-1:0] rem_next;

  // Quotient kept for the unreduced case
  logic [DATA_WIDTH-1:0] quotient;

  // One restoring step
  logic [DATA_WIDTH-1:0] divisor;
  logic [DATA_WIDTH:0]   trial;
  logic [DATA_WIDTH:0]   diff;
  logic                  fits;

  ////////////////////////////////////////
  // Restoring step
  ////////////////////////////////////////

  // First pass divides by A, second pass by the modulus
  assign modulo_pass = (step >= DATA_WIDTH);
  assign divisor     = modulo_pass ? modulo : data_a;

  // Bring down the next dividend bit
  assign trial = {rem, work[DATA_WIDTH-1]};
  assign diff  = trial - {1'b0, divisor};

  // Zero divisor always fits, so the quotient fills with ones
  assign fits = (trial >= {1'b0, divisor});

  // Remainder stays below the divisor, top bit is always clear
  assign rem_next  = fits ? diff[DATA_WIDTH-1:0] : trial[DATA_WIDTH-1:0];
  assign work_next = {work[DATA_WIDTH-2:0], fits};

  // Step markers
  assign quot_end  = (step == DATA_WIDTH - 1);
  assign last_step = (step == DIVIDE_STEPS - 2);

  ////////////////////////////////////////
  // Sequencing
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy <= 1'b0;
      step <= '0;
      done <= 1'b0;
    end else begin
      // Done is a single pulse
      done <= 1'b0;
      if (!busy) begin
        if (start) begin
          busy <= 1'b1;
          step <= '0;
        end
      end else begin
        step <= step + 1'b1;
        if (last_step) begin
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (!busy) begin
      // Load cycle
      if (start) begin
        work <= data_b;
        rem  <= '0;
      end
    end else begin
      work <= work_next;

      // Quotient complete, restart remainder for the modulus pass
      if (quot_end) begin
        rem      <= '0;
        quotient <= work_next;
      end else begin
        rem <= rem_next;
      end

      // Modulus of zero means no reduction
      if (last_step) begin
        result <= (modulo == '0) ? quotient : rem_next;
      end
    end
  end

endmodule

// ==== hdl/ntm_element_dispatcher.sv ====
`timescale 1ns/1ns

module ntm_element_dispatcher
  import ntm_divider_pkg::*;
(
  input  logic                   CLK,
  input  logic                   RST,
  input  logic                   START,
  input  logic [INDEX_WIDTH-1:0] SIZE_IN,
  input  logic [DATA_WIDTH-1:0]  MODULO_IN,
  input  logic [DATA_WIDTH-1:0]  DATA_A_IN,
  input  logic [DATA_WIDTH-1:0]  DATA_B_IN,
  input  logic                   DATA_A_IN_ENABLE,
  input  logic                   DATA_B_IN_ENABLE,
  input  logic                   lane_done_0,
  input  logic                   lane_done_1,
  input  logic                   slot_full_0,
  input  logic                   slot_full_1,
  output logic                   ACCEPT,
  output logic                   lane_start_0,
  output logic                   lane_start_1,
  output logic [DATA_WIDTH-1:0]  lane_a_0,
  output logic [DATA_WIDTH-1:0]  lane_b_0,
  output logic [DATA_WIDTH-1:0]  lane_a_1,
  output logic [DATA_WIDTH-1:0]  lane_b_1,
  output logic [DATA_WIDTH-1:0]  lane_modulo,
  output logic                   vector_start,
  output logic [INDEX_WIDTH-1:0] vector_size,
  output logic                   empty_vector
);

  ////////////////////////////////////////
  // Signals
  ////////////////////////////////////////

  // Idle, taking operands, waiting on a lane or draining
  typedef enum logic [1:0] {
    st_idle,
    st_input,
    st_issue
  } state_t;

  state_t state;

  // Vector progress
  logic [INDEX_WIDTH-1:0] size_q;
  logic [INDEX_WIDTH-1:0] issued_count;
  logic                   last_elem;

  // Lane bookkeeping
  logic [LANE_COUNT-1:0]     lane_busy;
  logic [LANE_COUNT-1:0]     lane_done;
  logic [LANE_COUNT-1:0]     slot_full;
  logic [LANE_SEL_WIDTH-1:0] target_lane;
  logic                      lane_free;
  logic                      drained;

  // Operand holding
  logic                  a_valid;
  logic                  b_valid;
  logic [DATA_WIDTH-1:0] a_q;
  logic [DATA_WIDTH-1:0] b_q;
  logic                  a_load;
  logic                  b_load;
  logic                  a_have;
  logic                  b_have;
  logic [DATA_WIDTH-1:0] a_next;
  logic [DATA_WIDTH-1:0] b_next;
  logic                  pair_ready;
  logic                  issue;

  ////////////////////////////////////////
  // Operand pairing
  ////////////////////////////////////////

  assign ACCEPT = (state == st_input);

  // Enables outside ACCEPT are dropped
  assign a_load = ACCEPT && DATA_A_IN_ENABLE;
  assign b_load = ACCEPT && DATA_B_IN_ENABLE;

  // Freshly loaded operand takes priority over the held one
  assign a_have = a_valid || a_load;
  assign b_have = b_valid || b_load;
  assign a_next = a_load ? DATA_A_IN : a_q;
  assign b_next = b_load ? DATA_B_IN : b_q;

  assign pair_ready = a_have && b_have;

  ////////////////////////////////////////
  // Lane selection
  ////////////////////////////////////////

  assign lane_done = {lane_done_1, lane_done_0};
  assign slot_full = {slot_full_1, slot_full_0};

  // Element k goes to lane k mod 2
  assign target_lane = issued_count[LANE_SEL_WIDTH-1:0];

  // Lane must be idle and its collector slot empty
  assign lane_free = !lane_busy[target_lane] && !slot_full[target_lane];
  assign issue     = pair_ready && lane_free;
  assign last_elem = (issued_count == size_q - 1'b1);

  // Every result has left the collector
  assign drained = (lane_busy == '0) && (slot_full == '0);

  assign vector_size = size_q;

  ////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state        <= st_idle;
      size_q       <= '0;
      issued_count <= '0;
      lane_busy    <= '0;
      a_valid      <= 1'b0;
      b_valid      <= 1'b0;
      lane_start_0 <= 1'b0;
      lane_start_1 <= 1'b0;
      vector_start <= 1'b0;
      empty_vector <= 1'b0;
    end else begin
      vector_start <= 1'b0;
      empty_vector <= 1'b0;
      lane_start_0 <= issue && (target_lane == '0);
      lane_start_1 <= issue && (target_lane == LANE_SEL_WIDTH'(1));

      // Busy from start pulse until done pulse
      for (int k = 0; k < LANE_COUNT; k++) begin
        if (lane_done[k]) begin
          lane_busy[k] <= 1'b0;
        end
      end
      if (issue) begin
        lane_busy[target_lane] <= 1'b1;
      end

      // Flags clear once the pair leaves for a lane
      a_valid <= issue ? 1'b0 : a_have;
      b_valid <= issue ? 1'b0 : b_have;

      case (state)
        st_idle: begin
          if (START) begin
            size_q       <= SIZE_IN;
            issued_count <= '0;
            if (SIZE_IN == '0) begin
              empty_vector <= 1'b1;
            end else begin
              vector_start <= 1'b1;
              state        <= st_input;
            end
          end
        end
        st_input, st_issue: begin
          if (issue) begin
            issued_count <= issued_count + 1'b1;
            // After the last element only the drain is left
            state <= last_elem ? st_issue : st_input;
          end else if (pair_ready) begin
            // Pair waits for its lane, input stalls
            state <= st_issue;
          end else if (state == st_issue && drained) begin
            state <= st_idle;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  ////////////////////////////////////////
  // Operand registers
  ////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (state == st_idle && START) begin
      lane_modulo <= MODULO_IN;
    end
    if (a_load) begin
      a_q <= DATA_A_IN;
    end
    if (b_load) begin
      b_q <= DATA_B_IN;
    end
    // Held steady by the lane until its done pulse
    if (issue && target_lane == '0) begin
      lane_a_0 <= a_next;
      lane_b_0 <= b_next;
    end
    if (issue && target_lane == LANE_SEL_WIDTH'(1)) begin
      lane_a_1 <= a_next;
      lane_b_1 <= b_next;
    end
  end

endmodule

// ==== hdl/ntm_result_collector.sv ====
`timescale 1ns/1ns

module ntm_result_collector
  import ntm_divider_pkg::*;
(
  input  logic                   CLK,
  input  logic                   RST,
  input  logic                   vector_start,
  input  logic [INDEX_WIDTH-1:0] vector_size,
  input  logic                   empty_vector,
  input  logic                   lane_done_0,
  input  logic                   lane_done_1,
  input  logic [DATA_WIDTH-1:0]  lane_result_0,
  input  logic [DATA_WIDTH-1:0]  lane_result_1,
  output logic                   slot_full_0,
  output logic                   slot_full_1,
  output logic [DATA_WIDTH-1:0]  DATA_OUT,
  output logic                   DATA_OUT_ENABLE,
  output logic                   READY
);

  ////////////////////////////////////////
  // Signals
  ////////////////////////////////////////

  // Lane inputs as arrays
  logic [LANE_COUNT-1:0] lane_done;
  logic [DATA_WIDTH-1:0] lane_result [LANE_COUNT];

  // One result slot per lane
  logic [LANE_COUNT-1:0] slot_full;
  logic [DATA_WIDTH-1:0] slot_data [LANE_COUNT];

  // Ordering
  logic [LANE_SEL_WIDTH-1:0] turn;
  logic [INDEX_WIDTH-1:0]    size_q;
  logic [INDEX_WIDTH-1:0]    sent_count;

  // Emission
  logic                  turn_full;
  logic                  turn_done;
  logic                  bypass;
  logic                  emit;
  logic [DATA_WIDTH-1:0] emit_data;

  assign lane_done      = {lane_done_1, lane_done_0};
  assign lane_result[0] = lane_result_0;
  assign lane_result[1] = lane_result_1;
  assign slot_full_0    = slot_full[0];
  assign slot_full_1    = slot_full[1];

  ////////////////////////////////////////
  // Merge in element order
  ////////////////////////////////////////

  assign turn_full = slot_full[turn];
  assign turn_done = lane_done[turn];

  // Result of the turn lane skips its slot
  assign bypass    = turn_done && !turn_full;
  assign emit      = turn_full || turn_done;
  assign emit_data = turn_full ? slot_data[turn] : lane_result[turn];

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      slot_full       <= '0;
      turn            <= '0;
      size_q          <= '0;
      sent_count      <= '0;
      DATA_OUT        <= '0;
      DATA_OUT_ENABLE <= 1'b0;
      READY           <= 1'b0;
    end else begin
      DATA_OUT_ENABLE <= emit;

      // Cycle after the last result, or straight from an empty vector
      READY <= empty_vector || (DATA_OUT_ENABLE && sent_count == size_q);

      // Out-of-turn results park until their turn
      for (int k = 0; k < LANE_COUNT; k++) begin
        if (lane_done[k] && !(bypass && turn == k)) begin
          slot_full[k] <= 1'b1;
        end
      end

      if (emit) begin
        if (turn_full) begin
          slot_full[turn] <= 1'b0;
        end
        DATA_OUT   <= emit_data;
        turn       <= turn + 1'b1;
        sent_count <= sent_count + 1'b1;
      end

      // New vector starts at lane 0
      if (vector_start) begin
        turn       <= '0;
        sent_count <= '0;
        size_q     <= vector_size;
      end
    end
  end

  // Slot payload
  always_ff @(posedge CLK) begin
    for (int k = 0; k < LANE_COUNT; k++) begin
      if (lane_done[k]) begin
        slot_data[k] <= lane_result[k];
      end
    end
  end

endmodule

// ==== hdl/ntm_vector_divider.sv ====
`timescale 1ns/1ns

module ntm_vector_divider
  import ntm_divider_pkg::*;
(
  input  logic                   CLK,
  input  logic                   RST,
  input  logic                   START,
  input  logic [INDEX_WIDTH-1:0] SIZE_IN,
  input  logic [DATA_WIDTH-1:0]  MODULO_IN,
  input  logic [DATA_WIDTH-1:0]  DATA_A_IN,
  input  logic [DATA_WIDTH-1:0]  DATA_B_IN,
  input  logic                   DATA_A_IN_ENABLE,
  input  logic                   DATA_B_IN_ENABLE,
  output logic                   ACCEPT,
  output logic [DATA_WIDTH-1:0]  DATA_OUT,
  output logic                   DATA_OUT_ENABLE,
  output logic                   READY
);

  ////////////////////////////////////////
  // Interconnect
  ////////////////////////////////////////

  // Dispatcher to lanes
  logic                  lane_start_0;
  logic                  lane_start_1;
  logic [DATA_WIDTH-1:0] lane_a_0;
  logic [DATA_WIDTH-1:0] lane_b_0;
  logic [DATA_WIDTH-1:0] lane_a_1;
  logic [DATA_WIDTH-1:0] lane_b_1;
  logic [DATA_WIDTH-1:0] lane_modulo;

  // Lanes to collector
  logic                  lane_done_0;
  logic                  lane_done_1;
  logic [DATA_WIDTH-1:0] lane_result_0;
  logic [DATA_WIDTH-1:0] lane_result_1;

  // Collector back to dispatcher
  logic slot_full_0;
  logic slot_full_1;

  // Vector framing
  logic                   vector_start;
  logic [INDEX_WIDTH-1:0] vector_size;
  logic                   empty_vector;

  ////////////////////////////////////////
  // Instances
  ////////////////////////////////////////

  ntm_element_dispatcher dispatcher (
    .CLK              (CLK),
    .RST              (RST),
    .START            (START),
    .SIZE_IN          (SIZE_IN),
    .MODULO_IN        (MODULO_IN),
    .DATA_A_IN        (DATA_A_IN),
    .DATA_B_IN        (DATA_B_IN),
    .DATA_A_IN_ENABLE (DATA_A_IN_ENABLE),
    .DATA_B_IN_ENABLE (DATA_B_IN_ENABLE),
    .lane_done_0      (lane_done_0),
    .lane_done_1      (lane_done_1),
    .slot_full_0      (slot_full_0),
    .slot_full_1      (slot_full_1),
    .ACCEPT           (ACCEPT),
    .lane_start_0     (lane_start_0),
    .lane_start_1     (lane_start_1),
    .lane_a_0         (lane_a_0),
    .lane_b_0         (lane_b_0),
    .lane_a_1         (lane_a_1),
    .lane_b_1         (lane_b_1),
    .lane_modulo      (lane_modulo),
    .vector_start     (vector_start),
    .vector_size      (vector_size),
    .empty_vector     (empty_vector)
  );

  // Even elements
  ntm_scalar_divider lane_0 (
    .CLK    (CLK),
    .RST    (RST),
    .start  (lane_start_0),
    .modulo (lane_modulo),
    .data_a (lane_a_0),
    .data_b (lane_b_0),
    .done   (lane_done_0),
    .result (lane_result_0)
  );

  // Odd elements
  ntm_scalar_divider lane_1 (
    .CLK    (CLK),
    .RST    (RST),
    .start  (lane_start_1),
    .modulo (lane_modulo),
    .data_a (lane_a_1),
    .data_b (lane_b_1),
    .done   (lane_done_1),
    .result (lane_result_1)
  );

  ntm_result_collector collector (
    .CLK             (CLK),
    .RST             (RST),
    .vector_start    (vector_start),
    .vector_size     (vector_size),
    .empty_vector    (empty_vector),
    .lane_done_0     (lane_done_0),
    .lane_done_1     (lane_done_1),
    .lane_result_0   (lane_result_0),
    .lane_result_1   (lane_result_1),
    .slot_full_0     (slot_full_0),
    .slot_full_1     (slot_full_1),
    .DATA_OUT        (DATA_OUT),
    .DATA_OUT_ENABLE (DATA_OUT_ENABLE),
    .READY           (READY)
  );

endmodule

// ==== tb/ntm_vector_divider_tasks.svh ====
////////////////////////////////////////
// Stimulus helpers
////////////////////////////////////////

// Returns 1 ns after the next rising edge
task automatic next_cycle();
  @(posedge CLK);
  #1;
endtask

// ACCEPT only changes on an edge
task automatic wait_accept();
  while (!ACCEPT) begin
    next_cycle();
  end
endtask

task automatic clear_elements();
  vec_a.delete();
  vec_b.delete();
endtask

task automatic add_element(input logic [DATA_WIDTH-1:0] a, input logic [DATA_WIDTH-1:0] b);
  vec_a.push_back(a);
  vec_b.push_back(b);
endtask

// Same cycle, or A first and B after a random gap
task automatic load_operand_pair(
  input logic [DATA_WIDTH-1:0] a,
  input logic [DATA_WIDTH-1:0] b,
  input bit                    split
);
  int gap;
  wait_accept();
  DATA_A_IN        = a;
  DATA_A_IN_ENABLE = 1'b1;
  if (!split) begin
    DATA_B_IN        = b;
    DATA_B_IN_ENABLE = 1'b1;
  end
  next_cycle();
  DATA_A_IN_ENABLE = 1'b0;
  DATA_B_IN_ENABLE = 1'b0;
  if (split) begin
    gap = $urandom_range(0, 3);
    repeat (gap) next_cycle();
    wait_accept();
    DATA_B_IN        = b;
    DATA_B_IN_ENABLE = 1'b1;
    next_cycle();
    DATA_B_IN_ENABLE = 1'b0;
  end
endtask

// Start, feed, collect until READY, compare
task automatic run_vector(input logic [DATA_WIDTH-1:0] modulo, input bit split);
  int size;
  int limit;
  int waited;
  size             = vec_a.size();
  limit            = size * (DIVIDE_STEPS + 10) + 50;
  waited           = 0;
  results.delete();
  ready_count      = 0;
  results_at_ready = 0;
  START            = 1'b1;
  SIZE_IN          = INDEX_WIDTH'(size);
  MODULO_IN        = modulo;
  next_cycle();
  START = 1'b0;
  foreach (vec_a[i]) begin
    load_operand_pair(vec_a[i], vec_b[i], split);
  end
  while (ready_count == 0 && waited < limit) begin
    next_cycle();
    waited++;
  end
  if (ready_count == 0) begin
    report_problem($sformatf("READY missing %0d cycles after the last operand", limit));
  end
  // Stray results after READY
  repeat (3) next_cycle();
  if (ready_count > 1) begin
    report_problem($sformatf("READY pulsed %0d times for one vector", ready_count));
  end
  if (ready_count > 0 && results_at_ready != size) begin
    report_problem($sformatf("%0d results before READY, expected %0d", results_at_ready, size));
  end
  if (results.size() != size) begin
    report_problem($sformatf("expected %0d results, got %0d", size, results.size()));
  end
  for (int i = 0; i < size && i < results.size(); i++) begin
    check_value($sformatf("DATA_OUT[%0d]", i), results[i],
                expected_result(vec_a[i], vec_b[i], modulo));
  end
endtask

task automatic check_idle_outputs();
  check_value("READY", READY, 0);
  check_value("DATA_OUT_ENABLE", DATA_OUT_ENABLE, 0);
  check_value("ACCEPT", ACCEPT, 0);
  check_value("DATA_OUT", DATA_OUT, 0);
endtask

////////////////////////////////////////
// Directed tests
////////////////////////////////////////

task automatic test_reset_and_single();
  int errors_before;
  errors_before = error_count;
  RST = 1'b1;
  next_cycle();
  check_idle_outputs();
  next_cycle();
  RST = 1'b0;
  check_idle_outputs();
  next_cycle();
  check_idle_outputs();
  // 1000 / 7 = 142, 142 mod 50 = 42
  clear_elements();
  add_element(16'd7, 16'd1000);
  run_vector(16'd50, 1'b0);
  if (results.size() > 0) begin
    check_value("DATA_OUT", results[0], 16'd42);
  end
  finish_test("reset_and_single", errors_before);
endtask

task automatic test_random_vector();
  int errors_before;
  errors_before = error_count;
  clear_elements();
  for (int i = 0; i < 12; i++) begin
    add_element(DATA_WIDTH'($urandom_range(1, 300)), DATA_WIDTH'($urandom_range(0, 16'hffff)));
  end
  run_vector(DATA_WIDTH'($urandom_range(2, 999)), 1'b0);
  finish_test("random_vector", errors_before);
endtask

// Every third divisor is zero
task automatic test_divide_by_zero();
  int errors_before;
  errors_before = error_count;
  clear_elements();
  for (int i = 0; i < 10; i++) begin
    if (i % 3 == 0) begin
      add_element('0, DATA_WIDTH'($urandom_range(0, 16'hffff)));
    end else begin
      add_element(DATA_WIDTH'($urandom_range(1, 40)), DATA_WIDTH'($urandom_range(0, 16'hffff)));
    end
  end
  run_vector(16'd97, 1'b0);
  finish_test("divide_by_zero", errors_before);
endtask

task automatic test_modulo_zero_split();
  int errors_before;
  errors_before = error_count;
  clear_elements();
  for (int i = 0; i < 8; i++) begin
    add_element(DATA_WIDTH'($urandom_range(1, 500)), DATA_WIDTH'($urandom_range(0, 16'hffff)));
  end
  run_vector('0, 1'b1);
  finish_test("modulo_zero_split", errors_before);
endtask

// Middle vector is empty
task automatic test_back_to_back();
  int errors_before;
  int lengths [3];
  errors_before = error_count;
  lengths[0] = 5;
  lengths[1] = 0;
  lengths[2] = 3;
  for (int v = 0; v < 3; v++) begin
    clear_elements();
    for (int i = 0; i < lengths[v]; i++) begin
      add_element(DATA_WIDTH'($urandom_range(1, 90)), DATA_WIDTH'($urandom_range(0, 16'hffff)));
    end
    run_vector(DATA_WIDTH'($urandom_range(1, 250)), 1'b0);
  end
  finish_test("back_to_back", errors_before);
endtask

// ==== tb/ntm_vector_divider_tb.sv ====
`timescale 1ns/1ns

module ntm_vector_divider_tb
  import ntm_divider_pkg::*;
();

  ////////////////////////////////////////
  // Run constants
  ////////////////////////////////////////

  localparam int          CLK_HALF = 2;
  localparam logic [31:0] SEED     = 32'h72eb_42f3;

  // Elements over all directed tests
  // 1 + 12 + 10 + 8 + (5 + 0 + 3)
  localparam int TOTAL_ELEMENTS  = 39;
  localparam int WATCHDOG_CYCLES = TOTAL_ELEMENTS * (DIVIDE_STEPS + 10) + 200;

  ////////////////////////////////////////
  // DUT signals
  ////////////////////////////////////////

  logic                   CLK;
  logic                   RST;
  logic                   START;
  logic [INDEX_WIDTH-1:0] SIZE_IN;
  logic [DATA_WIDTH-1:0]  MODULO_IN;
  logic [DATA_WIDTH-1:0]  DATA_A_IN;
  logic [DATA_WIDTH-1:0]  DATA_B_IN;
  logic                   DATA_A_IN_ENABLE;
  logic                   DATA_B_IN_ENABLE;
  logic                   ACCEPT;
  logic [DATA_WIDTH-1:0]  DATA_OUT;
  logic                   DATA_OUT_ENABLE;
  logic                   READY;

  // Operands of the current vector, element order
  logic [DATA_WIDTH-1:0] vec_a [$];
  logic [DATA_WIDTH-1:0] vec_b [$];

  // Results as they leave the DUT
  logic [DATA_WIDTH-1:0] results [$];
  int                    ready_count;
  int                    results_at_ready;

  // Bookkeeping
  int error_count;
  int test_count;
  int failed_tests;

  ntm_vector_divider ntm_vector_divider_i (
    .CLK              (CLK),
    .RST              (RST),
    .START            (START),
    .SIZE_IN          (SIZE_IN),
    .MODULO_IN        (MODULO_IN),
    .DATA_A_IN        (DATA_A_IN),
    .DATA_B_IN        (DATA_B_IN),
    .DATA_A_IN_ENABLE (DATA_A_IN_ENABLE),
    .DATA_B_IN_ENABLE (DATA_B_IN_ENABLE),
    .ACCEPT           (ACCEPT),
    .DATA_OUT         (DATA_OUT),
    .DATA_OUT_ENABLE  (DATA_OUT_ENABLE),
    .READY            (READY)
  );

  ////////////////////////////////////////
  // Clock and watchdog
  ////////////////////////////////////////

  initial begin
    CLK = 1'b0;
    forever #(CLK_HALF) CLK = ~CLK;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge CLK);
    $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Testbench failed");
    $finish;
  end

  // Outputs sampled mid-cycle, away from the edge
  always @(negedge CLK) begin
    if (!RST) begin
      // Results seen before the first READY
      if (READY) begin
        if (ready_count == 0) begin
          results_at_ready = results.size();
        end
        ready_count++;
      end
      if (DATA_OUT_ENABLE) begin
        results.push_back(DATA_OUT);
      end
    end
  end

  ////////////////////////////////////////
  // Reference model and checking
  ////////////////////////////////////////

  // Quotient of B by A, then remainder by the modulus
  function automatic logic [DATA_WIDTH-1:0] expected_result(
    input logic [DATA_WIDTH-1:0] a,
    input logic [DATA_WIDTH-1:0] b,
    input logic [DATA_WIDTH-1:0] modulo
  );
    logic [DATA_WIDTH-1:0] quotient;
    // Zero divisor saturates
    if (a == '0) begin
      quotient = '1;
    end else begin
      quotient = b / a;
    end
    if (modulo == '0) begin
      return quotient;
    end
    return quotient % modulo;
  endfunction

  task automatic check_value(
    input string       name,
    input logic [31:0] actual,
    input logic [31:0] expected
  );
    if (actual !== expected) begin
      error_count++;
      $display("ERR %s: got 0x%0h, expected 0x%0h at %0t", name, actual, expected, $time);
    end
  endtask

  task automatic report_problem(input string msg);
    error_count++;
    $display("Problem at %0t: %s", $time, msg);
  endtask

  task automatic finish_test(input string name, input int errors_before);
    test_count++;
    if (error_count == errors_before) begin
      $display("%s: ok", name);
    end else begin
      failed_tests++;
      $display("%s: %0d errors", name, error_count - errors_before);
    end
  endtask

  `include "ntm_vector_divider_tasks.svh"

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    RST              = 1'b1;
    START            = 1'b0;
    SIZE_IN          = '0;
    MODULO_IN        = '0;
    DATA_A_IN        = '0;
    DATA_B_IN        = '0;
    DATA_A_IN_ENABLE = 1'b0;
    DATA_B_IN_ENABLE = 1'b0;
    ready_count      = 0;
    results_at_ready = 0;
    error_count      = 0;
    test_count       = 0;
    failed_tests     = 0;
    void'($urandom(SEED));

    test_reset_and_single();
    test_random_vector();
    test_divide_by_zero();
    test_modulo_zero_split();
    test_back_to_back();

    $display("Tests run: %0d, tests with errors: %0d, total errors: %0d",
             test_count, failed_tests, error_count);
    if (error_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+tb
hdl/ntm_divider_pkg.sv
hdl/ntm_scalar_divider.sv
hdl/ntm_element_dispatcher.sv
hdl/ntm_result_collector.sv
hdl/ntm_vector_divider.sv
tb/ntm_vector_divider_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the vector divider testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=ntm_vector_divider_tb
LOG=sim.log

verilator --binary -Wno-fatal -f filelist.f --top-module "$TOP" -o "$TOP"
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Testbench failed" "$LOG"; then
  exit 1
fi

if ! grep -q "Testbench passed" "$LOG"; then
  echo "Simulation ended without a result line"
  exit 1
fi

exit 0
